//--- tb.f
+incdir+include
source/cdp_rdma_reg_pkg.sv
source/csb_reg_port.sv
source/rdma_pingpong_ctrl.sv
source/rdma_dual_group.sv
source/cdp_rdma_reg.sv
sim/tb_clk_gen.sv
sim/cdp_rdma_reg_properties.sv
sim/cdp_rdma_reg_tb.sv

//--- Makefile
# Verilator build and run of the register file testbench

VERILATOR ?= verilator
TOP       ?= cdp_rdma_reg_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/tb_defs.svh
`ifndef TB_DEFS_SVH
`define TB_DEFS_SVH

`define TB_SEED       32'h16fa_bbf6  // single seed for $urandom
`define TB_TIMEOUT    200            // cycles per response wait
`define TB_UNMAPPED   12'h030        // past last dual register
`define TB_STALL0     32'h0000_1234  // stall input, group 0
`define TB_STALL1     32'h0000_5678  // stall input, group 1
`define TB_D1_WIDTH   32'h0000_0040
`define TB_D1_BASE_LO 32'h8000_0000
`define TB_LOCK_VAL   32'h0000_0abc  // write attempted while locked

`endif

//--- sim/cdp_rdma_reg_tb.sv
`timescale 1ns/10ps
`include "tb_defs.svh"

module cdp_rdma_reg_tb;

  localparam int unsigned OP_EN_DELAY = 3;  // default launch depth
  localparam int          NUM_FIELDS  = 7;  // width .. surface stride

  logic                        nvdla_core_clk;
  logic                        nvdla_core_rstn;
  logic                        csb_req_pvld;
  cdp_rdma_reg_pkg::csb_req_t  csb_req_pd;
  logic                        csb_req_prdy;
  logic                        csb_resp_valid;
  cdp_rdma_reg_pkg::csb_resp_t csb_resp_pd;
  logic                        dp2reg_done;
  cdp_rdma_reg_pkg::reg_data_t dp2reg_d0_perf_read_stall;
  cdp_rdma_reg_pkg::reg_data_t dp2reg_d1_perf_read_stall;
  cdp_rdma_reg_pkg::rdma_cfg_t reg2dp_cfg;
  logic                        reg2dp_op_en;

  cdp_rdma_reg_pkg::reg_data_t exp_cfg [2][NUM_FIELDS];  // host view per group

  tb_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(3)) u_clk_gen (.nvdla_core_clk, .nvdla_core_rstn);

  cdp_rdma_reg #(.OP_EN_DELAY(OP_EN_DELAY)) dut (
    .nvdla_core_clk, .nvdla_core_rstn, .csb_req_pvld, .csb_req_pd, .csb_req_prdy,
    .csb_resp_valid, .csb_resp_pd, .dp2reg_done, .dp2reg_d0_perf_read_stall,
    .dp2reg_d1_perf_read_stall, .reg2dp_cfg, .reg2dp_op_en
  );

  // field i sits one word above field i-1
  function automatic cdp_rdma_reg_pkg::reg_offset_t field_ofs(input int idx);
    return cdp_rdma_reg_pkg::WIDTH_OFS + cdp_rdma_reg_pkg::reg_offset_t'(4 * idx);
  endfunction

  function automatic cdp_rdma_reg_pkg::reg_data_t field_mask(input int idx);
    return (idx < 3) ? 32'h0000_1fff : 32'hffff_ffff;  // cube dims keep 13 bits
  endfunction

  task automatic report_fail();
    $display("FAIL: see errors above");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
      report_fail();
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_response();
    int unsigned cyc;
    cyc = 0;
    do begin
      @(negedge nvdla_core_clk);
      cyc++;
    end while (!csb_resp_valid && cyc < `TB_TIMEOUT);
    if (!csb_resp_valid) begin
      $display("timeout while waiting for a CSB response");
      report_fail();
      $fatal(1, "response timeout");
    end
    check_value("csb_req_prdy", 32'd1, {31'd0, csb_req_prdy});  // host never stalled
    check_value("csb_resp_pd.error", 32'd0, {31'd0, csb_resp_pd.error});
  endtask

  //////////////////////////////////////////////////
  // host requests, driven on the falling edge
  //////////////////////////////////////////////////
  task automatic csb_write(input cdp_rdma_reg_pkg::reg_offset_t ofs,
                           input cdp_rdma_reg_pkg::reg_data_t data, input logic nposted);
    @(negedge nvdla_core_clk);
    csb_req_pvld       = 1'b1;
    csb_req_pd         = '0;
    csb_req_pd.addr    = 22'(ofs >> 2);  // byte offset to word address
    csb_req_pd.wdat    = data;
    csb_req_pd.write   = 1'b1;
    csb_req_pd.nposted = nposted;
    @(negedge nvdla_core_clk);
    csb_req_pvld = 1'b0;
    if (nposted) begin
      wait_response();
      check_value("csb_resp_pd.rdata", 32'd0, csb_resp_pd.rdata);  // write ack carries no data
    end
  endtask

  task automatic read_expect(input cdp_rdma_reg_pkg::reg_offset_t ofs,
                             input cdp_rdma_reg_pkg::reg_data_t exp);
    @(negedge nvdla_core_clk);
    csb_req_pvld    = 1'b1;
    csb_req_pd      = '0;
    csb_req_pd.addr = 22'(ofs >> 2);
    @(negedge nvdla_core_clk);
    csb_req_pvld = 1'b0;
    wait_response();
    check_value($sformatf("csb_resp_pd.rdata[0x%03h]", ofs), exp, csb_resp_pd.rdata);
  endtask

  task automatic pulse_done();
    @(negedge nvdla_core_clk);
    dp2reg_done = 1'b1;
    @(negedge nvdla_core_clk);
    dp2reg_done = 1'b0;  // now just past the done edge
  endtask

  // cycles from the trigger edge until the datapath sees op_en
  task automatic measure_launch();
    int unsigned cyc;
    cyc = 0;
    check_value("reg2dp_op_en", 32'd0, {31'd0, reg2dp_op_en});
    while (!reg2dp_op_en && cyc < `TB_TIMEOUT) begin
      @(negedge nvdla_core_clk);
      cyc++;
    end
    if (!reg2dp_op_en) begin
      $display("timeout while waiting for reg2dp_op_en to rise");
      report_fail();
      $fatal(1, "launch timeout");
    end
    check_value("reg2dp_op_en delay", OP_EN_DELAY, cyc);
  endtask

  task automatic check_cfg(input int g);
    check_value("reg2dp_cfg.width", exp_cfg[g][0], 32'(reg2dp_cfg.width));
    check_value("reg2dp_cfg.height", exp_cfg[g][1], 32'(reg2dp_cfg.height));
    check_value("reg2dp_cfg.channel", exp_cfg[g][2], 32'(reg2dp_cfg.channel));
    check_value("reg2dp_cfg.base_low", exp_cfg[g][3], reg2dp_cfg.base_low);
    check_value("reg2dp_cfg.base_high", exp_cfg[g][4], reg2dp_cfg.base_high);
    check_value("reg2dp_cfg.line_stride", exp_cfg[g][5], reg2dp_cfg.line_stride);
    check_value("reg2dp_cfg.surface_stride", exp_cfg[g][6], reg2dp_cfg.surface_stride);
  endtask

  // random fill of the producer group, mixed posted and non-posted
  task automatic program_group(input int g);
    cdp_rdma_reg_pkg::reg_data_t val;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      val = $urandom;
      csb_write(field_ofs(i), val, 1'(i % 2));
      exp_cfg[g][i] = val & field_mask(i);
    end
  endtask

  // concurrent assertion failures end the run here
  always @(negedge nvdla_core_clk) begin
    if (dut.u_props.assert_fail_cnt != 0) begin
      $display("a concurrent assertion on the DUT ports failed");
      report_fail();
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    int unsigned cyc;
    void'($urandom(`TB_SEED));
    csb_req_pvld              = 1'b0;
    csb_req_pd                = '0;
    dp2reg_done               = 1'b0;
    dp2reg_d0_perf_read_stall = `TB_STALL0;
    dp2reg_d1_perf_read_stall = `TB_STALL1;
    cyc                       = 0;
    while (!nvdla_core_rstn && cyc < `TB_TIMEOUT) begin
      @(negedge nvdla_core_clk);
      cyc++;
    end
    if (!nvdla_core_rstn) begin
      $display("timeout while waiting for reset release");
      report_fail();
      $fatal(1, "reset timeout");
    end

    ////////////////////////////////////////////////
    // read-back of both groups
    ////////////////////////////////////////////////
    for (int g = 0; g < 2; g++) begin
      csb_write(cdp_rdma_reg_pkg::POINTER_OFS, 32'(g), 1'b1);  // producer = g
      program_group(g);
      for (int i = 0; i < NUM_FIELDS; i++) begin
        read_expect(field_ofs(i), exp_cfg[g][i]);
      end
      read_expect(cdp_rdma_reg_pkg::PERF_STALL_OFS, (g == 0) ? `TB_STALL0 : `TB_STALL1);
      read_expect(cdp_rdma_reg_pkg::OP_ENABLE_OFS, 32'd0);
      read_expect(`TB_UNMAPPED, 32'd0);  // hole past the map
    end
    read_expect(cdp_rdma_reg_pkg::POINTER_OFS, 32'h0000_0001);  // producer 1, consumer 0

    // launch of group 0
    csb_write(cdp_rdma_reg_pkg::POINTER_OFS, 32'd0, 1'b1);
    check_cfg(0);
    csb_write(cdp_rdma_reg_pkg::OP_ENABLE_OFS, 32'd1, 1'b0);
    @(negedge nvdla_core_clk);  // group bit is set here
    measure_launch();
    read_expect(cdp_rdma_reg_pkg::STATUS_OFS, 32'h0000_0002);  // group 0 running

    ////////////////////////////////////////////////
    // ping-pong switch to group 1
    ////////////////////////////////////////////////
    csb_write(cdp_rdma_reg_pkg::POINTER_OFS, 32'd1, 1'b1);
    csb_write(cdp_rdma_reg_pkg::WIDTH_OFS, `TB_D1_WIDTH, 1'b1);
    exp_cfg[1][0] = `TB_D1_WIDTH & field_mask(0);
    csb_write(cdp_rdma_reg_pkg::BASE_LOW_OFS, `TB_D1_BASE_LO, 1'b1);
    exp_cfg[1][3] = `TB_D1_BASE_LO;
    csb_write(cdp_rdma_reg_pkg::OP_ENABLE_OFS, 32'd1, 1'b1);
    read_expect(cdp_rdma_reg_pkg::OP_ENABLE_OFS, 32'd1);
    read_expect(cdp_rdma_reg_pkg::STATUS_OFS, 32'h0001_0002);  // g1 pending, g0 running
    pulse_done();
    check_cfg(1);
    measure_launch();
    read_expect(cdp_rdma_reg_pkg::POINTER_OFS, 32'h0001_0001);
    read_expect(cdp_rdma_reg_pkg::STATUS_OFS, 32'h0002_0000);  // g1 running, g0 idle

    // write lock on the enabled group
    csb_write(cdp_rdma_reg_pkg::WIDTH_OFS, `TB_LOCK_VAL, 1'b1);  // dropped
    read_expect(cdp_rdma_reg_pkg::WIDTH_OFS, exp_cfg[1][0]);
    check_cfg(1);
    pulse_done();  // frees group 1, consumer back to 0
    read_expect(cdp_rdma_reg_pkg::OP_ENABLE_OFS, 32'd0);
    csb_write(cdp_rdma_reg_pkg::WIDTH_OFS, `TB_LOCK_VAL, 1'b1);
    exp_cfg[1][0] = `TB_LOCK_VAL & field_mask(0);
    read_expect(cdp_rdma_reg_pkg::WIDTH_OFS, exp_cfg[1][0]);
    check_cfg(0);

    repeat (2) @(negedge nvdla_core_clk);
    if (dut.u_props.assert_fail_cnt != 0) begin
      report_fail();
      $fatal(1, "run ended with failures");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

//--- sim/cdp_rdma_reg_properties.sv
`timescale 1ns/10ps

module cdp_rdma_reg_properties #(
  parameter int unsigned OP_EN_DELAY = 3
) (
  input logic                        nvdla_core_clk,
  input logic                        nvdla_core_rstn,
  input logic                        csb_req_pvld,
  input cdp_rdma_reg_pkg::csb_req_t  csb_req_pd,
  input logic                        csb_resp_valid,
  input cdp_rdma_reg_pkg::csb_resp_t csb_resp_pd,
  input logic                        dp2reg_done,
  input logic                        reg2dp_op_en,
  input logic                        d0_op_en,
  input logic                        d1_op_en
);

  int unsigned assert_fail_cnt = 0;  // polled from the testbench top
  logic        resp_want;            // read or non-posted write

  assign resp_want = csb_req_pvld & (~csb_req_pd.write | csb_req_pd.nposted);

  //////////////////////////////////////////////////
  // host response protocol
  //////////////////////////////////////////////////
  resp_after_req: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $past(resp_want, 2) |-> csb_resp_valid)
    else begin
      assert_fail_cnt++;
      $error("no response two edges after request");
    end

  // posted writes and idle cycles give no response
  resp_only_on_req: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_resp_valid |-> $past(resp_want, 2))
    else begin
      assert_fail_cnt++;
      $error("response without a matching request");
    end

  resp_type_bit: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_resp_valid |-> (csb_resp_pd.is_write_resp == $past(csb_req_pd.write, 2)))
    else begin
      assert_fail_cnt++;
      $error("response type bit differs from request");
    end

  quiet_in_reset: assert property (@(posedge nvdla_core_clk)
    !nvdla_core_rstn |-> (!csb_resp_valid && !reg2dp_op_en))
    else begin
      assert_fail_cnt++;
      $error("outputs active during reset");
    end

  //////////////////////////////////////////////////
  // launch and done
  //////////////////////////////////////////////////
  launch_after_delay: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $rose(reg2dp_op_en) |-> $past(d0_op_en | d1_op_en, OP_EN_DELAY))
    else begin
      assert_fail_cnt++;
      $error("op_en launched without a set group bit");
    end

  done_drops_op_en: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dp2reg_done |=> !reg2dp_op_en)
    else begin
      assert_fail_cnt++;
      $error("op_en still high after done");
    end

endmodule

// group bits are wires of the top level
bind cdp_rdma_reg cdp_rdma_reg_properties #(.OP_EN_DELAY(OP_EN_DELAY)) u_props (
  .nvdla_core_clk(nvdla_core_clk), .nvdla_core_rstn(nvdla_core_rstn),
  .csb_req_pvld(csb_req_pvld), .csb_req_pd(csb_req_pd), .csb_resp_valid(csb_resp_valid),
  .csb_resp_pd(csb_resp_pd), .dp2reg_done(dp2reg_done), .reg2dp_op_en(reg2dp_op_en),
  .d0_op_en(d0_op_en), .d1_op_en(d1_op_en)
);

//--- sim/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 10,
  parameter int unsigned RESET_CYCLES = 3
) (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #(PERIOD_NS / 2) nvdla_core_clk = ~nvdla_core_clk;
  end

  // reset low from time zero, released on a falling edge
  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
  end

endmodule

//--- source/cdp_rdma_reg.sv
`timescale 1ns/10ps

module cdp_rdma_reg #(
  parameter int unsigned OP_EN_DELAY = 3
) (
  input  logic                        nvdla_core_clk,
  input  logic                        nvdla_core_rstn,
  input  logic                        csb_req_pvld,
  input  cdp_rdma_reg_pkg::csb_req_t  csb_req_pd,
  output logic                        csb_req_prdy,
  output logic                        csb_resp_valid,
  output cdp_rdma_reg_pkg::csb_resp_t csb_resp_pd,
  input  logic                        dp2reg_done,
  input  cdp_rdma_reg_pkg::reg_data_t dp2reg_d0_perf_read_stall,
  input  cdp_rdma_reg_pkg::reg_data_t dp2reg_d1_perf_read_stall,
  output cdp_rdma_reg_pkg::rdma_cfg_t reg2dp_cfg,
  output logic                        reg2dp_op_en
);

  cdp_rdma_reg_pkg::reg_offset_t reg_offset;
  cdp_rdma_reg_pkg::reg_data_t   reg_wr_data;
  cdp_rdma_reg_pkg::reg_data_t   reg_rd_data;
  logic                          reg_wr_en;
  logic                          d0_wr_en, d1_wr_en;
  logic                          d0_op_en, d1_op_en;
  logic                          d0_op_en_trigger, d1_op_en_trigger;
  cdp_rdma_reg_pkg::rdma_cfg_t   d0_cfg, d1_cfg;
  cdp_rdma_reg_pkg::reg_data_t   d0_rd_data, d1_rd_data;

  // host side
  csb_reg_port u_port (
    .nvdla_core_clk, .nvdla_core_rstn, .csb_req_pvld, .csb_req_pd, .csb_req_prdy,
    .csb_resp_valid, .csb_resp_pd, .reg_offset, .reg_wr_data, .reg_wr_en, .reg_rd_en(),
    .reg_rd_data
  );

  rdma_pingpong_ctrl #(.OP_EN_DELAY(OP_EN_DELAY)) u_ctrl (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_offset, .reg_wr_data, .reg_wr_en, .dp2reg_done,
    .d0_op_en_trigger, .d1_op_en_trigger, .d0_cfg, .d1_cfg, .d0_rd_data, .d1_rd_data,
    .d0_wr_en, .d1_wr_en, .d0_op_en, .d1_op_en, .reg_rd_data, .reg2dp_cfg, .reg2dp_op_en
  );

  // ping and pong groups
  rdma_dual_group u_group0 (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_offset, .reg_wr_data, .wr_en(d0_wr_en),
    .op_en(d0_op_en), .perf_read_stall(dp2reg_d0_perf_read_stall), .cfg(d0_cfg),
    .op_en_trigger(d0_op_en_trigger), .rd_data(d0_rd_data)
  );

  rdma_dual_group u_group1 (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_offset, .reg_wr_data, .wr_en(d1_wr_en),
    .op_en(d1_op_en), .perf_read_stall(dp2reg_d1_perf_read_stall), .cfg(d1_cfg),
    .op_en_trigger(d1_op_en_trigger), .rd_data(d1_rd_data)
  );

endmodule

//--- source/rdma_dual_group.sv
`timescale 1ns/10ps

module rdma_dual_group (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  cdp_rdma_reg_pkg::reg_offset_t reg_offset,
  input  cdp_rdma_reg_pkg::reg_data_t   reg_wr_data,
  input  logic                          wr_en,
  input  logic                          op_en,
  input  cdp_rdma_reg_pkg::reg_data_t   perf_read_stall,
  output cdp_rdma_reg_pkg::rdma_cfg_t   cfg,
  output logic                          op_en_trigger,
  output cdp_rdma_reg_pkg::reg_data_t   rd_data
);

  //////////////////////////////////////////////////
  // config fields
  //////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cfg <= '0;
    end else if (wr_en) begin
      case (reg_offset)
        cdp_rdma_reg_pkg::WIDTH_OFS: begin
          cfg.width <= cdp_rdma_reg_pkg::cube_dim_t'(reg_wr_data);  // low 13 bits
        end
        cdp_rdma_reg_pkg::HEIGHT_OFS: begin
          cfg.height <= cdp_rdma_reg_pkg::cube_dim_t'(reg_wr_data);
        end
        cdp_rdma_reg_pkg::CHANNEL_OFS: begin
          cfg.channel <= cdp_rdma_reg_pkg::cube_dim_t'(reg_wr_data);
        end
        cdp_rdma_reg_pkg::BASE_LOW_OFS: begin
          cfg.base_low <= reg_wr_data;
        end
        cdp_rdma_reg_pkg::BASE_HIGH_OFS: begin
          cfg.base_high <= reg_wr_data;
        end
        cdp_rdma_reg_pkg::LINE_STRIDE_OFS: begin
          cfg.line_stride <= reg_wr_data;
        end
        cdp_rdma_reg_pkg::SURF_STRIDE_OFS: begin
          cfg.surface_stride <= reg_wr_data;
        end
        default: begin
        end
      endcase
    end
  end

  // op_en bit itself is held in the ping-pong control
  assign op_en_trigger = wr_en & (reg_offset == cdp_rdma_reg_pkg::OP_ENABLE_OFS);

  //////////////////////////////////////////////////
  // read-back
  //////////////////////////////////////////////////
  always_comb begin
    case (reg_offset)
      cdp_rdma_reg_pkg::OP_ENABLE_OFS: rd_data = {31'b0, op_en};
      cdp_rdma_reg_pkg::WIDTH_OFS: begin
        rd_data = cdp_rdma_reg_pkg::reg_data_t'(cfg.width);  // zero extended
      end
      cdp_rdma_reg_pkg::HEIGHT_OFS: begin
        rd_data = cdp_rdma_reg_pkg::reg_data_t'(cfg.height);
      end
      cdp_rdma_reg_pkg::CHANNEL_OFS: begin
        rd_data = cdp_rdma_reg_pkg::reg_data_t'(cfg.channel);
      end
      cdp_rdma_reg_pkg::BASE_LOW_OFS:    rd_data = cfg.base_low;
      cdp_rdma_reg_pkg::BASE_HIGH_OFS:   rd_data = cfg.base_high;
      cdp_rdma_reg_pkg::LINE_STRIDE_OFS: rd_data = cfg.line_stride;
      cdp_rdma_reg_pkg::SURF_STRIDE_OFS: rd_data = cfg.surface_stride;
      cdp_rdma_reg_pkg::PERF_STALL_OFS:  rd_data = perf_read_stall;  // live counter
      default:                           rd_data = '0;  // unmapped
    endcase
  end

endmodule

//--- source/rdma_pingpong_ctrl.sv
`timescale 1ns/10ps

module rdma_pingpong_ctrl #(
  parameter int unsigned OP_EN_DELAY = 3
) (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  cdp_rdma_reg_pkg::reg_offset_t reg_offset,
  input  cdp_rdma_reg_pkg::reg_data_t   reg_wr_data,
  input  logic                          reg_wr_en,
  input  logic                          dp2reg_done,
  input  logic                          d0_op_en_trigger,
  input  logic                          d1_op_en_trigger,
  input  cdp_rdma_reg_pkg::rdma_cfg_t   d0_cfg,
  input  cdp_rdma_reg_pkg::rdma_cfg_t   d1_cfg,
  input  cdp_rdma_reg_pkg::reg_data_t   d0_rd_data,
  input  cdp_rdma_reg_pkg::reg_data_t   d1_rd_data,
  output logic                          d0_wr_en,
  output logic                          d1_wr_en,
  output logic                          d0_op_en,
  output logic                          d1_op_en,
  output cdp_rdma_reg_pkg::reg_data_t   reg_rd_data,
  output cdp_rdma_reg_pkg::rdma_cfg_t   reg2dp_cfg,
  output logic                          reg2dp_op_en
);

  logic                          producer;   // group the host programs
  logic                          consumer;   // group the datapath runs
  logic                          select_s;
  logic                          select_d0;
  logic                          select_d1;
  cdp_rdma_reg_pkg::grp_status_t status_0;
  cdp_rdma_reg_pkg::grp_status_t status_1;
  cdp_rdma_reg_pkg::reg_data_t   s_rd_data;
  logic                          op_en_ori;
  logic [OP_EN_DELAY-1:0]        op_en_pipe;

  //////////////////////////////////////////////////
  // address decode and write gating
  //////////////////////////////////////////////////
  assign select_s  = (reg_offset < cdp_rdma_reg_pkg::DUAL_BASE);
  assign select_d0 = ~select_s & ~producer;
  assign select_d1 = ~select_s & producer;

  assign d0_wr_en = reg_wr_en & select_d0 & ~d0_op_en;  // locked while enabled
  assign d1_wr_en = reg_wr_en & select_d1 & ~d1_op_en;

  //////////////////////////////////////////////////
  // pointers and op_en bits
  //////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
      consumer <= 1'b0;
    end else begin
      if (reg_wr_en && select_s && reg_offset == cdp_rdma_reg_pkg::POINTER_OFS) begin
        producer <= reg_wr_data[0];
      end
      if (dp2reg_done) begin
        consumer <= ~consumer;  // hand over to the other group
      end
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      d0_op_en <= 1'b0;
      d1_op_en <= 1'b0;
    end else begin
      if (~d0_op_en & d0_op_en_trigger) begin
        d0_op_en <= reg_wr_data[0];
      end else if (dp2reg_done & ~consumer) begin
        d0_op_en <= 1'b0;  // group 0 finished
      end
      if (~d1_op_en & d1_op_en_trigger) begin
        d1_op_en <= reg_wr_data[0];
      end else if (dp2reg_done & consumer) begin
        d1_op_en <= 1'b0;  // group 1 finished
      end
    end
  end

  // status per group
  assign status_0 = ~d0_op_en ? cdp_rdma_reg_pkg::GRP_IDLE :
                    ~consumer ? cdp_rdma_reg_pkg::GRP_RUNNING : cdp_rdma_reg_pkg::GRP_PENDING;
  assign status_1 = ~d1_op_en ? cdp_rdma_reg_pkg::GRP_IDLE :
                    consumer  ? cdp_rdma_reg_pkg::GRP_RUNNING : cdp_rdma_reg_pkg::GRP_PENDING;

  //////////////////////////////////////////////////
  // read-back merge
  //////////////////////////////////////////////////
  always_comb begin
    case (reg_offset)
      cdp_rdma_reg_pkg::POINTER_OFS: s_rd_data = {15'b0, consumer, 15'b0, producer};
      cdp_rdma_reg_pkg::STATUS_OFS:  s_rd_data = {14'b0, status_1, 14'b0, status_0};
      default:                       s_rd_data = '0;
    endcase
  end

  assign reg_rd_data = select_s ? s_rd_data : (producer ? d1_rd_data : d0_rd_data);

  //////////////////////////////////////////////////
  // launch delay and active config
  //////////////////////////////////////////////////
  assign op_en_ori = consumer ? d1_op_en : d0_op_en;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_pipe <= '0;
    end else if (dp2reg_done) begin
      op_en_pipe <= '0;  // drop op_en right after done
    end else begin
      op_en_pipe[0] <= op_en_ori;
      for (int i = 1; i < OP_EN_DELAY; i++) begin
        op_en_pipe[i] <= op_en_pipe[i-1];
      end
    end
  end

  assign reg2dp_op_en = op_en_pipe[OP_EN_DELAY-1];
  assign reg2dp_cfg   = consumer ? d1_cfg : d0_cfg;  // follows consumer, no flop

endmodule

//--- source/csb_reg_port.sv
`timescale 1ns/10ps

module csb_reg_port (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  logic                          csb_req_pvld,
  input  cdp_rdma_reg_pkg::csb_req_t    csb_req_pd,
  output logic                          csb_req_prdy,
  output logic                          csb_resp_valid,
  output cdp_rdma_reg_pkg::csb_resp_t   csb_resp_pd,
  output cdp_rdma_reg_pkg::reg_offset_t reg_offset,
  output cdp_rdma_reg_pkg::reg_data_t   reg_wr_data,
  output logic                          reg_wr_en,
  output logic                          reg_rd_en,
  input  cdp_rdma_reg_pkg::reg_data_t   reg_rd_data
);

  logic                       req_pvld;
  cdp_rdma_reg_pkg::csb_req_t req_pd;
  logic                       resp_needed;
  cdp_rdma_reg_pkg::csb_resp_t resp_w;

  assign csb_req_prdy = 1'b1;  // never back-pressure the host

  //////////////////////////////////////////////////
  // request capture
  //////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld <= 1'b0;
    end else begin
      req_pvld <= csb_req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb_req_pvld) begin
      req_pd <= csb_req_pd;  // payload only loads on valid
    end
  end

  // word address to byte offset, top bits fall outside the 4 KB window
  assign reg_offset  = {req_pd.addr[cdp_rdma_reg_pkg::REG_OFS_W-3:0], 2'b00};
  assign reg_wr_data = req_pd.wdat;
  assign reg_wr_en   = req_pvld & req_pd.write;
  assign reg_rd_en   = req_pvld & ~req_pd.write;

  assign resp_needed = reg_rd_en | (reg_wr_en & req_pd.nposted);  // posted writes stay silent

  // read returns data, write returns zero with type bit set
  always_comb begin
    resp_w.is_write_resp = ~reg_rd_en;
    resp_w.error         = 1'b0;
    resp_w.rdata         = reg_rd_en ? reg_rd_data : '0;
  end

  //////////////////////////////////////////////////
  // response register
  //////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      csb_resp_valid <= 1'b0;
    end else begin
      csb_resp_valid <= resp_needed;  // one cycle pulse
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (resp_needed) begin
      csb_resp_pd <= resp_w;
    end
  end

endmodule

//--- source/cdp_rdma_reg_pkg.sv
package cdp_rdma_reg_pkg;

  //////////////////////////////////////////////////
  // field widths
  //////////////////////////////////////////////////
  localparam int unsigned REG_DATA_W  = 32;
  localparam int unsigned REG_OFS_W   = 12;  // 4 KB window per unit
  localparam int unsigned CUBE_DIM_W  = 13;
  localparam int unsigned CSB_ADDR_W  = 22;  // word address from host

  typedef logic [REG_DATA_W-1:0] reg_data_t;
  typedef logic [REG_OFS_W-1:0]  reg_offset_t;
  typedef logic [CUBE_DIM_W-1:0] cube_dim_t;

  // host request word, 63 bits
  typedef struct packed {
    logic [1:0]            level;    // decoded, not used
    logic [3:0]            wrbe;     // byte enables, not used
    logic                  srcpriv;  // decoded, not used
    logic                  nposted;  // write wants a response
    logic                  write;
    reg_data_t             wdat;
    logic [CSB_ADDR_W-1:0] addr;
  } csb_req_t;

  // response word, 34 bits, same layout for read and write
  typedef struct packed {
    logic      is_write_resp;
    logic      error;
    reg_data_t rdata;
  } csb_resp_t;

  // per-group configuration seen by the datapath
  typedef struct packed {
    cube_dim_t width;
    cube_dim_t height;
    cube_dim_t channel;
    reg_data_t base_low;
    reg_data_t base_high;
    reg_data_t line_stride;
    reg_data_t surface_stride;
  } rdma_cfg_t;

  typedef enum logic [1:0] {
    GRP_IDLE    = 2'd0,  // op_en clear
    GRP_PENDING = 2'd1,  // op_en set, waiting for consumer
    GRP_RUNNING = 2'd2   // op_en set, group is consumer
  } grp_status_t;

  //////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////
  localparam reg_offset_t POINTER_OFS     = 12'h000;
  localparam reg_offset_t STATUS_OFS      = 12'h004;
  localparam reg_offset_t DUAL_BASE       = 12'h008;  // first dual group offset
  localparam reg_offset_t OP_ENABLE_OFS   = 12'h008;
  localparam reg_offset_t WIDTH_OFS       = 12'h00c;
  localparam reg_offset_t HEIGHT_OFS      = 12'h010;
  localparam reg_offset_t CHANNEL_OFS     = 12'h014;
  localparam reg_offset_t BASE_LOW_OFS    = 12'h018;
  localparam reg_offset_t BASE_HIGH_OFS   = 12'h01c;
  localparam reg_offset_t LINE_STRIDE_OFS = 12'h020;
  localparam reg_offset_t SURF_STRIDE_OFS = 12'h024;
  localparam reg_offset_t PERF_STALL_OFS  = 12'h028;  // read only

endpackage
